// File: dsm_pkg.sv
/*
 * Shared definitions for the DSM status subsystem
 *   line memory geometry, request and response structs
 *   DSM line offsets and the DSM line address helper
 *   to-host ring geometry, identification words, CSR and ring status
 */
package dsm_pkg;

    // ==================================================
    // Line memory
    // ==================================================

    localparam int n_words_per_line = 4;
    localparam int n_lines = 16;

    typedef logic [$clog2(n_lines)-1:0] t_line_addr;
    typedef logic [n_words_per_line-1:0] t_word_mask;

    // Word 0 sits in the low 32 bits of the line
    typedef logic [n_words_per_line-1:0][31:0] t_line;

    typedef struct packed {
        logic       we;
        t_line_addr addr;
        t_word_mask mask;
        t_line      data;
    } t_mem_req;

    typedef struct packed {
        logic  valid;
        t_line data;
    } t_mem_rsp;

    // ==================================================
    // Host shared layout
    // ==================================================

    // Line offsets relative to the DSM base, fixed by the host driver
    typedef logic [1:0] t_dsm_offset;

    localparam t_dsm_offset off_afu_id = 2'd0;
    localparam t_dsm_offset off_debug = 2'd1;
    localparam t_dsm_offset off_ring_status = 2'd2;
    localparam t_dsm_offset off_poll = 2'd3;

    // Free-running ring count, the low bits select the slot
    typedef logic [3:0] t_ring_cnt;

    localparam t_line_addr ring_base = 4'd8;
    localparam int ring_depth = 8;

    // The identification words fill words 0 to 2 of the ID line
    // Word 3 carries the ring depth so the host can size its reader
    localparam logic [2:0][31:0] afu_id_words = {32'hc000c966, 32'h0d824272, 32'h9aeffe5f};

    typedef struct packed {
        t_line_addr dsm_base;
        logic       dsm_base_valid;
        logic       enable_test;
        logic [1:0] debug_idx;
    } t_csr_state;

    typedef struct packed {
        t_ring_cnt   next_write;
        logic [15:0] sent_total;
    } t_ring_status;

    // DSM lines wrap within the memory
    function automatic t_line_addr dsm_line_addr(t_line_addr base, t_dsm_offset off);
        return base + t_line_addr'(off);
    endfunction

endpackage

// File: apb_csr.sv
/*
 * APB slave for the host side
 *   CTRL, DSM_BASE and DEBUG registers with the test and debug pulses
 *   word-wide window into the shared line memory
 */
module apb_csr
(
    input  logic                 clk,
    input  logic                 resetb,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [11:0]          paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    output dsm_pkg::t_csr_state  csr,
    output logic                 mem_req_valid,
    output dsm_pkg::t_mem_req    mem_req,
    input  logic                 mem_grant,
    input  dsm_pkg::t_mem_rsp    mem_rsp
);
    import dsm_pkg::*;

    localparam logic [11:0] addr_ctrl = 12'h000;
    localparam logic [11:0] addr_base = 12'h004;
    localparam logic [11:0] addr_debug = 12'h008;

    logic access;
    logic sel_ctrl;
    logic sel_base;
    logic sel_debug;
    logic sel_reg;
    logic sel_win;
    logic reg_write;
    logic rd_wait;
    logic [1:0] win_word;

    // ==================================================
    // Address decode
    // ==================================================

    assign access = psel && penable;
    assign sel_ctrl = (paddr == addr_ctrl);
    assign sel_base = (paddr == addr_base);
    assign sel_debug = (paddr == addr_debug);
    assign sel_reg = sel_ctrl || sel_base || sel_debug;

    // The window covers 0x100 to 0x1FC, one 16 byte block per line
    assign sel_win = (paddr[11:8] == 4'h1);
    assign win_word = paddr[3:2];

    assign reg_write = access && pwrite && sel_reg;

    // Registers and unmapped addresses finish at once
    // Window writes finish on the grant, reads when the line comes back
    always_comb
    begin
        pready = 1'b0;
        if (access)
        begin
            if (!sel_win)
                pready = 1'b1;
            else if (pwrite)
                pready = mem_grant;
            else
                pready = rd_wait && mem_rsp.valid;
        end
    end

    assign pslverr = access && !sel_win && !sel_reg;

    always_comb
    begin
        prdata = '0;
        if (access)
        begin
            if (sel_ctrl)
                prdata = {31'b0, csr.dsm_base_valid};
            else if (sel_base)
                prdata = 32'(csr.dsm_base);
            else if (sel_win && !pwrite)
                prdata = mem_rsp.data[win_word];
        end
    end

    // ==================================================
    // Memory window
    // ==================================================

    // Stop requesting once a read is granted and only the data is awaited
    assign mem_req_valid = access && sel_win && !rd_wait;

    always_comb
    begin
        mem_req.we = pwrite;
        mem_req.addr = paddr[7:4];
        mem_req.mask = t_word_mask'(1) << win_word;
        // Every word carries the write data, the mask picks the one that lands
        mem_req.data = {n_words_per_line{pwdata}};
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
            rd_wait <= 1'b0;
        else if (mem_grant && !pwrite)
            rd_wait <= 1'b1;
        else if (rd_wait && mem_rsp.valid)
            rd_wait <= 1'b0;
    end

    // ==================================================
    // Control registers
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            csr <= '0;
        end
        else
        begin
            // Both pulses last exactly one cycle
            csr.enable_test <= reg_write && sel_ctrl && pwdata[1];
            csr.debug_idx <= (reg_write && sel_debug) ? pwdata[1:0] : 2'b0;
            if (reg_write && sel_ctrl)
                csr.dsm_base_valid <= pwdata[0];
            if (reg_write && sel_base)
                csr.dsm_base <= pwdata[3:0];
        end
    end

endmodule

// File: line_arbiter.sv
/*
 * Round-robin arbiter in front of the line memory
 *   one grant per cycle, registered routing of read responses
 */
module line_arbiter
#(
    parameter int n_clients = 3,
    parameter type req_t = dsm_pkg::t_mem_req
)
(
    input  logic                 clk,
    input  logic                 resetb,
    input  logic [n_clients-1:0] req_valid,
    input  req_t                 reqs [n_clients],
    output logic [n_clients-1:0] grant,
    output logic                 mem_en,
    output req_t                 mem_req,
    input  dsm_pkg::t_mem_rsp    mem_rsp,
    output dsm_pkg::t_mem_rsp    rsps [n_clients]
);

    localparam int idx_w = (n_clients > 1) ? $clog2(n_clients) : 1;

    logic [idx_w-1:0] ptr;
    logic [idx_w-1:0] sel;
    logic [idx_w-1:0] last_idx;
    logic last_rd;

    // Search from the pointer upward and take the first valid client
    always_comb
    begin
        int idx;
        sel = ptr;
        mem_en = 1'b0;
        for (int k = 0; k < n_clients; k++)
        begin
            idx = (int'(ptr) + k) % n_clients;
            if (!mem_en && req_valid[idx])
            begin
                mem_en = 1'b1;
                sel = idx_w'(idx);
            end
        end
    end

    assign grant = mem_en ? (n_clients'(1) << sel) : '0;
    assign mem_req = reqs[sel];

    // The pointer moves past the winner, so it has lowest priority next time
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            ptr <= '0;
            last_rd <= 1'b0;
        end
        else
        begin
            last_rd <= mem_en && !mem_req.we;
            if (mem_en)
                ptr <= (sel == idx_w'(n_clients - 1)) ? '0 : sel + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        last_idx <= sel;
    end

    // The memory answers one cycle after the grant, only the reader sees valid
    always_comb
    begin
        for (int i = 0; i < n_clients; i++)
        begin
            rsps[i].valid = mem_rsp.valid && last_rd && (last_idx == idx_w'(i));
            rsps[i].data = mem_rsp.data;
        end
    end

endmodule

// File: line_memory.sv
/*
 * Single-port line memory holding the DSM
 *   word write enables, registered read data
 */
module line_memory
(
    input  logic              clk,
    input  logic              en,
    input  dsm_pkg::t_mem_req req,
    output dsm_pkg::t_mem_rsp rsp
);
    import dsm_pkg::*;

    t_line mem [n_lines];

    always_ff @(posedge clk)
    begin
        if (en && req.we)
        begin
            for (int w = 0; w < n_words_per_line; w++)
            begin
                if (req.mask[w])
                    mem[req.addr][w] <= req.data[w];
            end
        end
    end

    // Read data lands one cycle after the request, flagged by valid
    always_ff @(posedge clk)
    begin
        rsp.valid <= en && !req.we;
        rsp.data <= mem[req.addr];
    end

endmodule

// File: status_manager.sv
/*
 * Status manager for the host link
 *   poll reader that brings the host read count into host_read
 *   writer for the ID, debug and ring status lines of the DSM
 */
module status_manager
(
    input  logic                  clk,
    input  logic                  resetb,
    input  dsm_pkg::t_csr_state   csr,
    input  dsm_pkg::t_ring_status ring,
    output dsm_pkg::t_ring_cnt    host_read,
    output logic                  mem_req_valid,
    output dsm_pkg::t_mem_req     mem_req,
    input  logic                  mem_grant,
    input  dsm_pkg::t_mem_rsp     mem_rsp
);
    import dsm_pkg::*;

    typedef enum logic {rd_poll, rd_wait} t_rd_state;
    typedef enum logic {wr_idle, wr_busy} t_wr_state;

    t_rd_state rd_state;
    t_wr_state wr_state;

    logic rd_req;
    logic wr_go;
    logic sel_wr;
    // Set while an offered write waits for its grant
    logic wr_shown;

    logic id_pend;
    logic dbg_pend;
    logic [1:0] dbg_idx;
    t_ring_cnt last_nw;

    logic load_id;
    logic load_dbg;
    logic load_stat;

    t_dsm_offset wr_off;
    t_line wr_line;

    t_line id_line;
    t_line dbg_line;
    t_line stat_line;

    // ==================================================
    // Line images
    // ==================================================

    always_comb
    begin
        id_line = '0;
        id_line[2:0] = afu_id_words;
        id_line[3] = 32'(ring_depth);

        // Word 3 echoes the request so the host knows which dump it sees
        dbg_line = '0;
        dbg_line[3] = 32'(dbg_idx);
        case (dbg_idx)
            2'd1: dbg_line[0] = 32'(ring.next_write);
            2'd2: dbg_line[0] = 32'(host_read);
            2'd3: dbg_line[0] = 32'(ring.sent_total);
            default: dbg_line[0] = '0;
        endcase

        stat_line = '0;
        stat_line[0] = 32'(ring.next_write);
        stat_line[1] = 32'(ring.sent_total);
    end

    // ==================================================
    // Shared client port
    // ==================================================

    assign rd_req = (rd_state == rd_poll) && csr.dsm_base_valid;
    assign wr_go = (wr_state == wr_busy) && csr.dsm_base_valid;

    // The reader wins a tie, but a write already on the port stays there
    assign sel_wr = wr_go && (wr_shown || !rd_req);
    assign mem_req_valid = rd_req || wr_go;

    always_comb
    begin
        if (sel_wr)
        begin
            mem_req.we = 1'b1;
            mem_req.addr = dsm_line_addr(csr.dsm_base, wr_off);
            mem_req.mask = '1;
            mem_req.data = wr_line;
        end
        else
        begin
            mem_req.we = 1'b0;
            mem_req.addr = dsm_line_addr(csr.dsm_base, off_poll);
            mem_req.mask = '0;
            mem_req.data = '0;
        end
    end

    // ==================================================
    // Poll reader
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            rd_state <= rd_poll;
            host_read <= '0;
        end
        else
        begin
            case (rd_state)
                rd_poll:
                begin
                    if (rd_req && !sel_wr && mem_grant)
                        rd_state <= rd_wait;
                end
                default:
                begin
                    // Word 0 of the poll line is the host's read count
                    if (mem_rsp.valid)
                    begin
                        host_read <= t_ring_cnt'(mem_rsp.data[0]);
                        rd_state <= rd_poll;
                    end
                end
            endcase
        end
    end

    // ==================================================
    // Status writer
    // ==================================================

    // Pick the next write in priority order while idle and the DSM is known
    always_comb
    begin
        load_id = 1'b0;
        load_dbg = 1'b0;
        load_stat = 1'b0;
        if (wr_state == wr_idle && csr.dsm_base_valid)
        begin
            if (id_pend)
                load_id = 1'b1;
            else if (dbg_pend)
                load_dbg = 1'b1;
            else if (ring.next_write != last_nw)
                load_stat = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wr_state <= wr_idle;
            wr_shown <= 1'b0;
            // The ID line goes out as soon as the DSM base is valid
            id_pend <= 1'b1;
            dbg_pend <= 1'b0;
            last_nw <= '0;
        end
        else
        begin
            wr_shown <= sel_wr && !mem_grant;
            if (load_id || load_dbg || load_stat)
                wr_state <= wr_busy;
            else if (sel_wr && mem_grant)
                wr_state <= wr_idle;

            if (load_id)
                id_pend <= 1'b0;
            if (load_dbg)
                dbg_pend <= 1'b0;
            if (load_stat)
                last_nw <= ring.next_write;

            // New requests arriving now override the clears above
            if (csr.enable_test)
                id_pend <= 1'b1;
            if (csr.debug_idx != 2'b0)
                dbg_pend <= 1'b1;
        end
    end

    // The chosen line is frozen so a held request never changes
    always_ff @(posedge clk)
    begin
        if (csr.debug_idx != 2'b0)
            dbg_idx <= csr.debug_idx;

        if (load_id)
        begin
            wr_off <= off_afu_id;
            wr_line <= id_line;
        end
        else if (load_dbg)
        begin
            wr_off <= off_debug;
            wr_line <= dbg_line;
        end
        else if (load_stat)
        begin
            wr_off <= off_ring_status;
            wr_line <= stat_line;
        end
    end

endmodule

// File: ring_writer.sv
/*
 * To-host ring writer
 *   takes one message at a time under credit and writes it as a ring line
 */
module ring_writer
(
    input  logic                  clk,
    input  logic                  resetb,
    input  logic                  msg_valid,
    input  logic [31:0]           msg_data,
    output logic                  msg_ready,
    input  dsm_pkg::t_ring_cnt    host_read,
    output dsm_pkg::t_ring_status ring,
    output logic                  mem_req_valid,
    output dsm_pkg::t_mem_req     mem_req,
    input  logic                  mem_grant
);
    import dsm_pkg::*;

    logic busy;
    logic ready;
    logic accept;
    logic [31:0] msg_q;
    t_ring_cnt nw_inc;

    // A slot is free while fewer than ring_depth lines are unread by the host
    function automatic logic has_credit(t_ring_cnt wr, t_ring_cnt rd);
        t_ring_cnt used;
        used = wr - rd;
        return used < t_ring_cnt'(ring_depth);
    endfunction

    assign msg_ready = ready;
    assign accept = msg_valid && ready;
    assign nw_inc = ring.next_write + 1'b1;

    // ==================================================
    // Accept and write control
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            busy <= 1'b0;
            ready <= 1'b0;
            ring <= '0;
        end
        else if (accept)
        begin
            busy <= 1'b1;
            ready <= 1'b0;
        end
        else if (busy && mem_grant)
        begin
            // The line is in memory, move both counts on together
            busy <= 1'b0;
            ring.next_write <= nw_inc;
            ring.sent_total <= ring.sent_total + 1'b1;
            ready <= has_credit(nw_inc, host_read);
        end
        else if (!busy)
        begin
            ready <= has_credit(ring.next_write, host_read);
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            msg_q <= msg_data;
    end

    // ==================================================
    // Ring line request
    // ==================================================

    assign mem_req_valid = busy;

    always_comb
    begin
        mem_req.we = 1'b1;
        mem_req.addr = ring_base + t_line_addr'(ring.next_write[$clog2(ring_depth)-1:0]);
        mem_req.mask = '1;
        mem_req.data = '0;
        mem_req.data[0] = msg_q;
        // Sequence number before this message is counted
        mem_req.data[1] = 32'(ring.sent_total);
    end

endmodule

// File: status_top.sv
/*
 * Top level of the DSM status subsystem
 *   APB slave, status manager and ring writer share the line memory
 */
module status_top
(
    input  logic        clk,
    input  logic        resetb,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        msg_valid,
    input  logic [31:0] msg_data,
    output logic        msg_ready
);
    import dsm_pkg::*;

    // Client order on the arbiter is APB window, status manager, ring writer
    localparam int n_clients = 3;

    t_csr_state csr;
    t_ring_status ring;
    t_ring_cnt host_read;

    logic [n_clients-1:0] req_valid;
    logic [n_clients-1:0] grant;
    t_mem_req reqs [n_clients];
    t_mem_rsp rsps [n_clients];

    logic mem_en;
    t_mem_req mem_req;
    t_mem_rsp mem_rsp;

    apb_csr u_apb_csr
    (
        .clk           (clk),
        .resetb        (resetb),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .csr           (csr),
        .mem_req_valid (req_valid[0]),
        .mem_req       (reqs[0]),
        .mem_grant     (grant[0]),
        .mem_rsp       (rsps[0])
    );

    status_manager u_status_manager
    (
        .clk           (clk),
        .resetb        (resetb),
        .csr           (csr),
        .ring          (ring),
        .host_read     (host_read),
        .mem_req_valid (req_valid[1]),
        .mem_req       (reqs[1]),
        .mem_grant     (grant[1]),
        .mem_rsp       (rsps[1])
    );

    // Writes only, so its response slot stays unread
    ring_writer u_ring_writer
    (
        .clk           (clk),
        .resetb        (resetb),
        .msg_valid     (msg_valid),
        .msg_data      (msg_data),
        .msg_ready     (msg_ready),
        .host_read     (host_read),
        .ring          (ring),
        .mem_req_valid (req_valid[2]),
        .mem_req       (reqs[2]),
        .mem_grant     (grant[2])
    );

    line_arbiter #(
        .n_clients (n_clients),
        .req_t     (t_mem_req)
    ) u_line_arbiter
    (
        .clk       (clk),
        .resetb    (resetb),
        .req_valid (req_valid),
        .reqs      (reqs),
        .grant     (grant),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .rsps      (rsps)
    );

    line_memory u_line_memory
    (
        .clk (clk),
        .en  (mem_en),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

// File: tb_clock.sv
/*
 * Testbench clock and reset generator
 *   free-running clock, active low reset released on a falling edge
 */
module tb_clock
#(
    parameter int half_period = 10,
    parameter int reset_cycles = 2
)
(
    output logic clk,
    output logic resetb
);
    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset is held for a fixed number of rising edges, then let go between edges
    initial
    begin
        resetb = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
    end

endmodule

// File: tb_top.sv
/*
 * Testbench top for the DSM status subsystem
 *   APB host model, LFSR message source and DSM line checks
 *   ID line, ring lines, credit, debug dump and test restart
 */
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Run limits and register map
    // ==================================================

    localparam int half_period = 10;
    localparam int reset_cycles = 2;
    localparam int n_tests = 5;
    // Every test finishes well inside this budget even with polling
    localparam int test_budget = 4000;
    localparam int max_cycles = n_tests * test_budget;
    localparam int poll_tries = 40;
    localparam int settle_cycles = 40;

    localparam logic [11:0] reg_ctrl = 12'h000;
    localparam logic [11:0] reg_base = 12'h004;
    localparam logic [11:0] reg_debug = 12'h008;
    localparam logic [11:0] reg_unmapped = 12'h040;

    logic clk;
    logic resetb;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic msg_valid;
    logic [31:0] msg_data;
    logic msg_ready;

    int errors;
    int checks;
    int tests_done;
    int test_errors;
    int cycles;
    logic [15:0] lfsr_state;
    // Messages waiting to be offered and those the DUT took in order
    logic [31:0] pending [$];
    logic [31:0] sent_msgs [$];
    logic taken;

    tb_clock #(
        .half_period  (half_period),
        .reset_cycles (reset_cycles)
    ) u_clock
    (
        .clk    (clk),
        .resetb (resetb)
    );

    status_top DUT
    (
        .clk       (clk),
        .resetb    (resetb),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .msg_valid (msg_valid),
        .msg_data  (msg_data),
        .msg_ready (msg_ready)
    );

    // ==================================================
    // Helpers
    // ==================================================

    // Galois LFSR stepped once per bit handed out
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 16'hb400;
        return out;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], next_bit()};
        return w;
    endfunction

    // Window layout is 0x100 plus 16 bytes per line plus 4 bytes per word
    function automatic logic [11:0] win_addr(logic [3:0] line, logic [1:0] word);
        return {4'h1, line, word, 2'b00};
    endfunction

    // ID line as the host driver knows it with the ring depth in word 3
    function automatic logic [31:0] id_word(int w);
        case (w)
            0: return 32'h9aeffe5f;
            1: return 32'h0d824272;
            2: return 32'hc000c966;
            default: return 32'd8;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Setup phase then access phase held until pready
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, input logic exp_err,
                              output logic [31:0] rdata);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        // pready has settled shortly after the falling edge
        #1;
        while (!pready)
        begin
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        check_value($sformatf("pslverr at %h", addr), 32'(pslverr), 32'(exp_err));
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, 1'b0, unused);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        apb_access(1'b0, addr, 32'd0, 1'b0, data);
    endtask

    // Host side polling of a DSM word until the FPGA has written it
    task automatic wait_for_word(input logic [3:0] line, input logic [1:0] word,
                                 input logic [31:0] exp, input string what);
        logic [31:0] got;
        int tries;
        tries = 1;
        apb_read(win_addr(line, word), got);
        while (got !== exp && tries < poll_tries)
        begin
            apb_read(win_addr(line, word), got);
            tries++;
        end
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERR %0t ns: %s never appeared in line %0d word %0d after %0d reads, last %h",
                     $time, what, line, word, tries, got);
            errors++;
        end
    endtask

    task automatic queue_msgs(input int n);
        @(posedge clk);
        repeat (n) pending.push_back(random_word());
    endtask

    // Waits for the count and then a little longer so that an extra message would show
    task automatic wait_sent(input int target, input string what);
        int waited;
        waited = 0;
        while (sent_msgs.size() < target && waited < test_budget)
        begin
            @(negedge clk);
            waited++;
        end
        repeat (settle_cycles) @(negedge clk);
        check_value(what, 32'(sent_msgs.size()), 32'(target));
    endtask

    // Ring starts at line 8 with 8 slots and word 1 holds the sequence number
    task automatic check_ring(input int first, input int last);
        logic [31:0] got;
        logic [3:0] line;
        for (int seq = first; seq <= last; seq++)
        begin
            line = 4'(8 + seq % 8);
            apb_read(win_addr(line, 2'd0), got);
            check_value($sformatf("ring line %0d message", line), got, sent_msgs[seq]);
            apb_read(win_addr(line, 2'd1), got);
            check_value($sformatf("ring line %0d sequence", line), got, 32'(seq));
        end
    endtask

    task automatic check_id_line(input string what);
        logic [31:0] got;
        wait_for_word(4'd0, 2'd0, id_word(0), what);
        for (int w = 1; w < 4; w++)
        begin
            apb_read(win_addr(4'd0, 2'(w)), got);
            check_value($sformatf("%s word %0d", what, w), got, id_word(w));
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("Test %0d %s finished, %0d errors", tests_done, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ==================================================
    // Message source
    // ==================================================

    // A message seen with ready high after the falling edge goes in on the next rising edge
    always
    begin
        @(negedge clk);
        if (taken)
        begin
            sent_msgs.push_back(msg_data);
            msg_valid = 1'b0;
        end
        if (!msg_valid && pending.size() > 0)
        begin
            msg_data = pending.pop_front();
            msg_valid = 1'b1;
        end
        #1;
        taken = msg_valid && msg_ready;
    end

    // ==================================================
    // Watchdog
    // ==================================================

    initial
    begin
        cycles = 0;
        while (cycles < max_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
        $display("Errors found");
        $finish;
    end

    // ==================================================
    // Tests
    // ==================================================

    initial
    begin
        logic [31:0] got;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        msg_valid = 1'b0;
        msg_data = '0;
        taken = 1'b0;
        errors = 0;
        checks = 0;
        tests_done = 0;
        test_errors = 0;
        lfsr_state = 16'd7446;
        wait (resetb === 1'b1);

        // Host clears its read count before the FPGA starts polling
        apb_write(win_addr(4'd3, 2'd0), 32'd0);
        // The base register first holds a value that differs from its reset state
        apb_write(reg_base, 32'd5);
        apb_read(reg_base, got);
        check_value("DSM_BASE first value", got, 32'd5);
        apb_write(reg_base, 32'd0);
        apb_write(reg_ctrl, 32'd1);
        check_id_line("ID line");
        apb_read(reg_base, got);
        check_value("DSM_BASE", got, 32'd0);
        apb_read(reg_ctrl, got);
        check_value("CTRL", got, 32'd1);
        apb_access(1'b0, reg_unmapped, 32'd0, 1'b1, got);
        check_value("unmapped read data", got, 32'd0);
        end_test("ID line and registers");

        queue_msgs(5);
        wait_sent(5, "messages accepted");
        wait_for_word(4'd2, 2'd0, 32'd5, "ring status next_write");
        apb_read(win_addr(4'd2, 2'd1), got);
        check_value("ring status sent_total", got, 32'd5);
        check_ring(0, 4);
        end_test("ring lines");

        // Host has read nothing, so only the three free slots fill up
        queue_msgs(12);
        wait_sent(8, "messages accepted without credit");
        apb_write(win_addr(4'd3, 2'd0), 32'd6);
        wait_sent(14, "messages accepted after host read 6");
        wait_for_word(4'd2, 2'd0, 32'd14, "ring status next_write");
        apb_read(win_addr(4'd2, 2'd1), got);
        check_value("ring status sent_total", got, 32'd14);
        check_ring(6, 13);
        @(posedge clk);
        pending.delete();
        end_test("ring credit and wrap");

        apb_write(reg_debug, 32'd2);
        wait_for_word(4'd1, 2'd3, 32'd2, "debug index 2");
        apb_read(win_addr(4'd1, 2'd0), got);
        check_value("debug host_read", got, 32'd6);
        apb_read(reg_debug, got);
        check_value("DEBUG read", got, 32'd0);
        apb_write(reg_debug, 32'd1);
        wait_for_word(4'd1, 2'd3, 32'd1, "debug index 1");
        apb_read(win_addr(4'd1, 2'd0), got);
        check_value("debug next_write", got, 32'd14);
        end_test("debug dump");

        for (int w = 0; w < 4; w++)
            apb_write(win_addr(4'd0, 2'(w)), 32'd0);
        apb_read(win_addr(4'd0, 2'd0), got);
        check_value("cleared ID word 0", got, 32'd0);
        // Bit 0 keeps the base valid and bit 1 starts the test
        apb_write(reg_ctrl, 32'd3);
        check_id_line("ID line after test start");
        apb_read(reg_ctrl, got);
        check_value("CTRL after test start", got, 32'd1);
        end_test("test restart");

        $display("Tests run %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: build.f
dsm_pkg.sv
apb_csr.sv
line_arbiter.sv
line_memory.sv
status_manager.sv
ring_writer.sv
status_top.sv
tb_clock.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the DSM status testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_top -f build.f -o tb_top_sim

output="$(./obj_dir/tb_top_sim)"
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
